// ==== common/issue_pkg.sv ====
package issue_pkg;

    ////////////////////////////////////////
    // basic widths
    ////////////////////////////////////////
    localparam int WORD_W = 32;
    localparam int IDX_W  = 5;

    typedef logic [WORD_W-1:0] word_t;     // data or instruction word
    typedef logic [IDX_W-1:0]  reg_idx_t;  // register index
    typedef logic [WORD_W-1:0] pc_t;

    ////////////////////////////////////////
    // queue sizing
    ////////////////////////////////////////
    localparam int QUEUE_DEPTH = 16;
    localparam int FULL_MARGIN = 4;        // room for one pair still in decode

    typedef logic [$clog2(QUEUE_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(QUEUE_DEPTH):0]   count_t;  // 0 .. QUEUE_DEPTH
    typedef logic [1:0]                     issue_num_t;

    ////////////////////////////////////////
    // packet layout
    ////////////////////////////////////////
    localparam int PKT_W = 76;

    typedef logic [PKT_W-1:0] pkt_t;

    localparam int PKT_PC_LSB   = 44;      // [75:44]
    localparam int PKT_INST_LSB = 12;      // [43:12]
    // rd is not stored twice, it is the rd field of the instruction itself
    localparam int PKT_RD_LSB   = PKT_INST_LSB + 7;
    localparam int PKT_RS1_LSB  = 7;       // [11:7], zero when unused
    localparam int PKT_RS2_LSB  = 2;       // [6:2], zero when unused
    localparam int PKT_WRD_BIT  = 1;
    localparam int PKT_URS2_BIT = 0;

    // opcodes that change the register flags
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    ////////////////////////////////////////
    // control register map
    ////////////////////////////////////////
    localparam logic [1:0] CSR_CTRL   = 2'd0;
    localparam logic [1:0] CSR_STATUS = 2'd1;
    localparam logic [1:0] CSR_ISSUED = 2'd2;

    localparam int CTRL_HOLD_BIT  = 0;
    localparam int CTRL_FLUSH_BIT = 1;

endpackage

// ==== hw/inst_decode.sv ====
module inst_decode (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_flush,
    input  logic [1:0]         i_fetch_valid,
    input  issue_pkg::pc_t     i_fetch_pc,
    input  issue_pkg::word_t   i_inst0,
    input  issue_pkg::word_t   i_inst1,
    input  logic               i_ready,
    output issue_pkg::pkt_t    o_pkt0,
    output issue_pkg::pkt_t    o_pkt1,
    output logic [1:0]         o_pkt_valid
);

    logic       accept;
    logic [1:0] pkt_valid_q;

    // builds one packet from an instruction word
    function automatic issue_pkg::pkt_t make_pkt(input issue_pkg::pc_t pc,
                                                 input issue_pkg::word_t inst);
        logic [6:0]      opc;
        logic            no_rd;
        logic            no_src;
        issue_pkg::pkt_t pkt;
        opc    = inst[6:0];
        no_rd  = (opc == issue_pkg::OPC_STORE) || (opc == issue_pkg::OPC_BRANCH);
        no_src = (opc == issue_pkg::OPC_LUI);
        pkt    = '0;
        pkt[issue_pkg::PKT_PC_LSB +: issue_pkg::WORD_W]   = pc;
        pkt[issue_pkg::PKT_INST_LSB +: issue_pkg::WORD_W] = inst;
        pkt[issue_pkg::PKT_RS1_LSB +: issue_pkg::IDX_W]   = no_src ? '0 : inst[19:15];
        pkt[issue_pkg::PKT_RS2_LSB +: issue_pkg::IDX_W]   = no_src ? '0 : inst[24:20];
        // x0 as destination never counts as a write
        pkt[issue_pkg::PKT_WRD_BIT]  = !no_rd &&
                                       (pkt[issue_pkg::PKT_RD_LSB +: issue_pkg::IDX_W] != '0);
        pkt[issue_pkg::PKT_URS2_BIT] = !no_src;
        return pkt;
    endfunction

    assign accept = i_ready && i_fetch_valid[0];  // slot 1 never valid alone

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pkt_valid_q <= 2'b00;
        end else begin
            pkt_valid_q <= accept ? i_fetch_valid : 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_pkt0 <= make_pkt(i_fetch_pc, i_inst0);
            o_pkt1 <= make_pkt(i_fetch_pc + issue_pkg::pc_t'(4), i_inst1);  // second slot pc
        end
    end

    // a pending pair dies with the flush, the new one above survives
    assign o_pkt_valid = pkt_valid_q & {2{~i_flush}};

endmodule

// ==== hw/issue_csr.sv ====
module issue_csr (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_wb_cyc,
    input  logic                   i_wb_stb,
    input  logic                   i_wb_we,
    input  logic [1:0]             i_wb_adr,
    input  issue_pkg::word_t       i_wb_dat,
    output issue_pkg::word_t       o_wb_dat,
    output logic                   o_wb_ack,
    input  issue_pkg::count_t      i_count,
    input  issue_pkg::issue_num_t  i_issue_num,
    output logic                   o_hold,
    output logic                   o_flush
);

    logic             req;       // new request, not yet acked
    logic             wr;
    issue_pkg::word_t issued;    // issued instruction counter
    issue_pkg::word_t rd_data;

    assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign wr  = req && i_wb_we;

    ////////////////////////////////////////
    // read mux
    ////////////////////////////////////////
    always_comb begin
        rd_data = '0;
        case (i_wb_adr)
            issue_pkg::CSR_CTRL:   rd_data[issue_pkg::CTRL_HOLD_BIT] = o_hold;  // flush reads 0
            issue_pkg::CSR_STATUS: rd_data = issue_pkg::word_t'(i_count);
            issue_pkg::CSR_ISSUED: rd_data = issued;
            default:               rd_data = '0;
        endcase
    end

    ////////////////////////////////////////
    // control state and counter
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_wb_ack <= 1'b0;
            o_hold   <= 1'b0;
            o_flush  <= 1'b0;
            issued   <= '0;
        end else begin
            o_wb_ack <= req;  // one cycle later, one cycle long
            o_flush  <= wr && (i_wb_adr == issue_pkg::CSR_CTRL) &&
                        i_wb_dat[issue_pkg::CTRL_FLUSH_BIT];
            if (wr && (i_wb_adr == issue_pkg::CSR_CTRL)) begin
                o_hold <= i_wb_dat[issue_pkg::CTRL_HOLD_BIT];
            end
            if (wr && (i_wb_adr == issue_pkg::CSR_ISSUED)) begin
                issued <= '0;  // clear wins over this cycle's issue
            end else begin
                issued <= issued + issue_pkg::word_t'(i_issue_num);
            end
        end
    end

    // read data captured with the ack
    always_ff @(posedge clk) begin
        if (req) begin
            o_wb_dat <= i_wb_we ? '0 : rd_data;
        end
    end

endmodule

// ==== hw/issue_top.sv ====
module issue_top (
    input  logic                 clk,
    input  logic                 rstn,
    // fetch
    input  logic [1:0]           i_fetch_valid,
    input  issue_pkg::pc_t       i_fetch_pc,
    input  issue_pkg::word_t     i_inst0,
    input  issue_pkg::word_t     i_inst1,
    output logic                 o_fetch_ready,
    // register write, stands in for writeback
    input  logic                 i_wr_en,
    input  issue_pkg::reg_idx_t  i_wr_addr,
    input  issue_pkg::word_t     i_wr_data,
    // wishbone slave
    input  logic                 i_wb_cyc,
    input  logic                 i_wb_stb,
    input  logic                 i_wb_we,
    input  logic [1:0]           i_wb_adr,
    input  issue_pkg::word_t     i_wb_dat,
    output issue_pkg::word_t     o_wb_dat,
    output logic                 o_wb_ack,
    // issue
    output logic [1:0]           o_iss_valid,
    output issue_pkg::pc_t       o_iss_pc0,
    output issue_pkg::pc_t       o_iss_pc1,
    output issue_pkg::word_t     o_iss_inst0,
    output issue_pkg::word_t     o_iss_inst1,
    output issue_pkg::word_t     o_opa0,
    output issue_pkg::word_t     o_opb0,
    output issue_pkg::word_t     o_opa1,
    output issue_pkg::word_t     o_opb1
);

    issue_pkg::pkt_t       pkt0, pkt1, head0, head1;
    logic [1:0]            pkt_valid;
    issue_pkg::issue_num_t avail, issue_num;
    issue_pkg::count_t     count;
    logic                  full, hold, flush;
    issue_pkg::reg_idx_t   a_rs1, a_rs2, b_rs1, b_rs2;

    assign o_fetch_ready = ~full;

    assign o_iss_pc0   = head0[issue_pkg::PKT_PC_LSB +: issue_pkg::WORD_W];
    assign o_iss_pc1   = head1[issue_pkg::PKT_PC_LSB +: issue_pkg::WORD_W];
    assign o_iss_inst0 = head0[issue_pkg::PKT_INST_LSB +: issue_pkg::WORD_W];
    assign o_iss_inst1 = head1[issue_pkg::PKT_INST_LSB +: issue_pkg::WORD_W];

    inst_decode u_decode (
        .clk(clk), .rstn(rstn), .i_flush(flush),
        .i_fetch_valid(i_fetch_valid), .i_fetch_pc(i_fetch_pc),
        .i_inst0(i_inst0), .i_inst1(i_inst1), .i_ready(o_fetch_ready),
        .o_pkt0(pkt0), .o_pkt1(pkt1), .o_pkt_valid(pkt_valid)
    );

    issue_queue u_queue (
        .clk(clk), .rstn(rstn), .i_flush(flush),
        .i_pkt0(pkt0), .i_pkt1(pkt1), .i_pkt_valid(pkt_valid), .i_issue_num(issue_num),
        .o_head0(head0), .o_head1(head1), .o_avail(avail), .o_count(count), .o_full(full),
        .o_a_rs1(a_rs1), .o_a_rs2(a_rs2), .o_b_rs1(b_rs1), .o_b_rs2(b_rs2)
    );

    issue_select u_select (
        .i_avail(avail), .i_hold(hold), .i_flush(flush),
        .i_head0(head0), .i_head1(head1),
        .o_issue_num(issue_num), .o_iss_valid(o_iss_valid)
    );

    reg_file u_rf (
        .clk(clk), .rstn(rstn),
        .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
        .i_raddr0(a_rs1), .i_raddr1(a_rs2), .i_raddr2(b_rs1), .i_raddr3(b_rs2),
        .o_rdata0(o_opa0), .o_rdata1(o_opb0), .o_rdata2(o_opa1), .o_rdata3(o_opb1)
    );

    issue_csr u_csr (
        .clk(clk), .rstn(rstn),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
        .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
        .i_count(count), .i_issue_num(issue_num), .o_hold(hold), .o_flush(flush)
    );

endmodule

// ==== hw/reg_file.sv ====
module reg_file (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_wr_en,
    input  issue_pkg::reg_idx_t  i_wr_addr,
    input  issue_pkg::word_t     i_wr_data,
    input  issue_pkg::reg_idx_t  i_raddr0,
    input  issue_pkg::reg_idx_t  i_raddr1,
    input  issue_pkg::reg_idx_t  i_raddr2,
    input  issue_pkg::reg_idx_t  i_raddr3,
    output issue_pkg::word_t     o_rdata0,
    output issue_pkg::word_t     o_rdata1,
    output issue_pkg::word_t     o_rdata2,
    output issue_pkg::word_t     o_rdata3
);

    issue_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin  // x0 stays zero
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // async reads see the old value during a write
    assign o_rdata0 = (i_raddr0 == '0) ? '0 : regs[i_raddr0];
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];
    assign o_rdata3 = (i_raddr3 == '0) ? '0 : regs[i_raddr3];

endmodule

// ==== issue_queue/issue_queue.sv ====
module issue_queue (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_flush,
    input  issue_pkg::pkt_t        i_pkt0,
    input  issue_pkg::pkt_t        i_pkt1,
    input  logic [1:0]             i_pkt_valid,
    input  issue_pkg::issue_num_t  i_issue_num,
    output issue_pkg::pkt_t        o_head0,
    output issue_pkg::pkt_t        o_head1,
    output issue_pkg::issue_num_t  o_avail,
    output issue_pkg::count_t      o_count,
    output logic                   o_full,
    output issue_pkg::reg_idx_t    o_a_rs1,
    output issue_pkg::reg_idx_t    o_a_rs2,
    output issue_pkg::reg_idx_t    o_b_rs1,
    output issue_pkg::reg_idx_t    o_b_rs2
);

    issue_pkg::pkt_t   mem [issue_pkg::QUEUE_DEPTH];

    issue_pkg::ptr_t   head;         // next slot to write
    issue_pkg::ptr_t   tail;         // oldest valid entry
    issue_pkg::ptr_t   head_p1;
    issue_pkg::ptr_t   tail_p1;

    issue_pkg::count_t num_add;      // packets written this cycle
    issue_pkg::count_t length_left;  // entries left after this cycle's issue
    issue_pkg::count_t length;       // occupancy after this edge

    ////////////////////////////////////////
    // length bookkeeping
    ////////////////////////////////////////
    assign num_add = i_pkt_valid[1] ? issue_pkg::count_t'(2) :
                     i_pkt_valid[0] ? issue_pkg::count_t'(1) : '0;

    // issue never exceeds avail, so no underflow here
    assign length_left = o_count - issue_pkg::count_t'(i_issue_num);
    assign length      = length_left + num_add;

    // depth is a power of two, pointers wrap on their own
    assign head_p1 = head + issue_pkg::ptr_t'(1);
    assign tail_p1 = tail + issue_pkg::ptr_t'(1);

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_pkt_valid[0]) begin
            mem[head] <= i_pkt0;
        end
        if (i_pkt_valid[1]) begin
            mem[head_p1] <= i_pkt1;
        end
    end

    ////////////////////////////////////////
    // pointers and status
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head    <= '0;
            tail    <= '0;
            o_count <= '0;
            o_avail <= '0;
            o_full  <= 1'b0;
        end else if (i_flush) begin
            tail    <= head;   // drop everything queued
            o_count <= '0;
            o_avail <= '0;
            o_full  <= 1'b0;
        end else begin
            head    <= head + issue_pkg::ptr_t'(num_add);
            tail    <= tail + issue_pkg::ptr_t'(i_issue_num);
            o_count <= length;
            if (length >= issue_pkg::count_t'(2)) begin
                o_avail <= issue_pkg::issue_num_t'(2);
            end else begin
                o_avail <= issue_pkg::issue_num_t'(length);
            end
            // full early enough for the pair still sitting in decode
            o_full  <= length >
                       issue_pkg::count_t'(issue_pkg::QUEUE_DEPTH - issue_pkg::FULL_MARGIN);
        end
    end

    ////////////////////////////////////////
    // head view
    ////////////////////////////////////////
    assign o_head0 = mem[tail];
    assign o_head1 = mem[tail_p1];

    assign o_a_rs1 = o_head0[issue_pkg::PKT_RS1_LSB +: issue_pkg::IDX_W];
    assign o_a_rs2 = o_head0[issue_pkg::PKT_RS2_LSB +: issue_pkg::IDX_W];
    assign o_b_rs1 = o_head1[issue_pkg::PKT_RS1_LSB +: issue_pkg::IDX_W];
    assign o_b_rs2 = o_head1[issue_pkg::PKT_RS2_LSB +: issue_pkg::IDX_W];

endmodule

// ==== issue_queue/issue_select.sv ====
module issue_select (
    input  issue_pkg::issue_num_t  i_avail,
    input  logic                   i_hold,
    input  logic                   i_flush,
    input  issue_pkg::pkt_t        i_head0,
    input  issue_pkg::pkt_t        i_head1,
    output issue_pkg::issue_num_t  o_issue_num,
    output logic [1:0]             o_iss_valid
);

    issue_pkg::reg_idx_t rd0;
    issue_pkg::reg_idx_t rs1_b;
    issue_pkg::reg_idx_t rs2_b;
    logic                wrd0;
    logic                urs2_b;
    logic                dep;

    assign rd0    = i_head0[issue_pkg::PKT_RD_LSB +: issue_pkg::IDX_W];
    assign wrd0   = i_head0[issue_pkg::PKT_WRD_BIT];
    assign rs1_b  = i_head1[issue_pkg::PKT_RS1_LSB +: issue_pkg::IDX_W];
    assign rs2_b  = i_head1[issue_pkg::PKT_RS2_LSB +: issue_pkg::IDX_W];
    assign urs2_b = i_head1[issue_pkg::PKT_URS2_BIT];

    // second packet needs the first one's result, x0 already filtered by wrd
    assign dep = wrd0 && ((rd0 == rs1_b) || (urs2_b && (rd0 == rs2_b)));

    always_comb begin
        if (i_hold || i_flush || (i_avail == '0)) begin
            o_issue_num = issue_pkg::issue_num_t'(0);
        end else if ((i_avail == issue_pkg::issue_num_t'(1)) || dep) begin
            o_issue_num = issue_pkg::issue_num_t'(1);
        end else begin
            o_issue_num = issue_pkg::issue_num_t'(2);
        end
    end

    // thermometer code, slot 0 first
    always_comb begin
        case (o_issue_num)
            2'd1:    o_iss_valid = 2'b01;
            2'd2:    o_iss_valid = 2'b11;
            default: o_iss_valid = 2'b00;
        endcase
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the issue stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_issue -Mdir obj_dir -o sim_issue

./obj_dir/sim_issue > sim.log
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== sim/tb_issue.sv ====
module tb_issue;

    localparam int TIMEOUT = 200;  // cycles per wait loop

    logic                  clk;
    logic                  rstn;
    logic [1:0]            i_fetch_valid;
    issue_pkg::pc_t        i_fetch_pc;
    issue_pkg::word_t      i_inst0, i_inst1;
    logic                  o_fetch_ready;
    logic                  i_wr_en;
    issue_pkg::reg_idx_t   i_wr_addr;
    issue_pkg::word_t      i_wr_data;
    logic                  i_wb_cyc, i_wb_stb, i_wb_we;
    logic [1:0]            i_wb_adr;
    issue_pkg::word_t      i_wb_dat, o_wb_dat;
    logic                  o_wb_ack;
    logic [1:0]            o_iss_valid;
    issue_pkg::pc_t        o_iss_pc0, o_iss_pc1;
    issue_pkg::word_t      o_iss_inst0, o_iss_inst1;
    issue_pkg::word_t      o_opa0, o_opb0, o_opa1, o_opb1;

    logic [31:0] shadow [32];                  // register file model
    logic [31:0] model_pc[$];                  // program order model
    logic [31:0] model_inst[$];
    int          iss_edge[$];                  // issue edge per issued slot
    int          iss_slot[$];
    int          cyc_cnt = 0;
    int          err_cnt = 0;
    int          model_issued = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err0;
    string       cur_test = "reset";
    logic [31:0] lcg_state = 32'd35;
    logic [31:0] next_pc = 32'h0000_1000;

    issue_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] gen_inst();
        logic [31:0] r;
        logic [6:0]  opc;
        r = lcg_next();
        case (r[31:29])
            3'd0:       opc = issue_pkg::OPC_STORE;
            3'd1:       opc = issue_pkg::OPC_BRANCH;
            3'd2:       opc = issue_pkg::OPC_LUI;
            3'd3:       opc = 7'b0000011;  // load
            3'd4, 3'd5: opc = 7'b0010011;  // op-imm
            default:    opc = 7'b0110011;
        endcase
        r = lcg_next();
        return {r[31:7], opc};
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rd, rs1, rs2);
        return {7'd0, rs2, rs1, 3'd0, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'd0, rd, 7'b0010011};
    endfunction

    // lui reads no source registers
    function automatic logic [31:0] exp_opa(input logic [31:0] inst);
        return (inst[6:0] == issue_pkg::OPC_LUI) ? 32'd0 : shadow[inst[19:15]];
    endfunction

    function automatic logic [31:0] exp_opb(input logic [31:0] inst);
        return (inst[6:0] == issue_pkg::OPC_LUI) ? 32'd0 : shadow[inst[24:20]];
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout while %s in test %s", what, cur_test);
        $display("Verification failed");
        $finish;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = err_cnt;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_cnt == test_err0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, err_cnt - test_err0);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (model_inst.size() != 0) begin
            if (n == TIMEOUT) abort_run("waiting for the queue to drain");
            @(posedge clk);
            #5;
            n++;
        end
    endtask

    ////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////
    task automatic fetch(input logic [1:0] vld, input logic [31:0] inst0, inst1,
                         output int acc_edge);
        int   n;
        logic rdy;
        n             = 0;
        rdy           = 1'b0;
        i_fetch_valid = vld;
        i_fetch_pc    = next_pc;
        i_inst0       = inst0;
        i_inst1       = inst1;
        while (!rdy) begin
            if (n == TIMEOUT) abort_run("waiting for fetch ready");
            rdy = o_fetch_ready;  // stable until the next edge
            @(posedge clk);
            #5;
            n++;
        end
        acc_edge = cyc_cnt;
        model_pc.push_back(next_pc);
        model_inst.push_back(inst0);
        if (vld[1]) begin
            model_pc.push_back(next_pc + 32'd4);
            model_inst.push_back(inst1);
        end
        next_pc       = next_pc + 32'd8;
        i_fetch_valid = 2'b00;
    endtask

    task automatic write_reg(input logic [4:0] adr, input logic [31:0] dat);
        i_wr_en   = 1'b1;
        i_wr_addr = adr;
        i_wr_data = dat;
        @(posedge clk);
        #5;
        if (adr != 5'd0) shadow[adr] = dat;
        i_wr_en = 1'b0;
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        n        = 0;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = wdat;
        @(posedge clk);
        #5;
        while (!o_wb_ack) begin
            if (n == TIMEOUT) abort_run("waiting for wishbone ack");
            @(posedge clk);
            #5;
            n++;
        end
        rdat     = o_wb_dat;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
        wb_access(1'b0, adr, 32'd0, dat);
    endtask

    ////////////////////////////////////////
    // issue monitor
    ////////////////////////////////////////
    task automatic check_slot(input int slot, input logic [31:0] pc, inst, opa, opb);
        logic [31:0] e_inst;
        iss_edge.push_back(cyc_cnt + 1);  // leaves at the coming edge
        iss_slot.push_back(slot);
        if (model_inst.size() == 0) begin
            $display("%s: slot %0d issued an instruction that was never fetched", cur_test, slot);
            err_cnt++;
            return;
        end
        e_inst = model_inst.pop_front();
        check_val("issue pc", model_pc.pop_front(), pc);
        check_val("issue inst", e_inst, inst);
        check_val("operand a", exp_opa(e_inst), opa);
        check_val("operand b", exp_opb(e_inst), opb);
        model_issued++;
    endtask

    always @(negedge clk) begin
        if (rstn) begin
            if (o_iss_valid == 2'b10) begin
                $display("%s: slot 1 issued without slot 0", cur_test);
                err_cnt++;
            end
            if (o_iss_valid[0]) check_slot(0, o_iss_pc0, o_iss_inst0, o_opa0, o_opb0);
            if (o_iss_valid[1]) check_slot(1, o_iss_pc1, o_iss_inst1, o_opa1, o_opb1);
        end
    end

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic test_reset_state();
        logic [31:0] rd;
        start_test("reset_state");
        check_val("iss_valid", 32'd0, 32'(o_iss_valid));
        check_val("fetch_ready", 32'd1, 32'(o_fetch_ready));
        check_val("wb_ack", 32'd0, 32'(o_wb_ack));
        wb_read(issue_pkg::CSR_CTRL, rd);
        check_val("ctrl", 32'd0, rd);
        wb_read(issue_pkg::CSR_ISSUED, rd);
        check_val("issued", 32'd0, rd);
        end_test();
    endtask

    task automatic test_indep_pair();
        int base;
        int acc;
        start_test("indep_pair");
        for (int i = 1; i <= 5; i++) begin
            write_reg(5'(i), 32'h1000_0000 + 32'(i) * 32'h111);
        end
        base = iss_edge.size();
        fetch(2'b11, r_type(5'd3, 5'd1, 5'd2), r_type(5'd6, 5'd4, 5'd5), acc);
        wait_drain();
        check_val("issued", 32'(base + 2), 32'(iss_edge.size()));
        check_val("edge slot 0", 32'(acc + 2), 32'(iss_edge[base]));
        check_val("edge slot 1", 32'(acc + 2), 32'(iss_edge[base + 1]));
        check_val("second slot", 32'd1, 32'(iss_slot[base + 1]));
        end_test();
    endtask

    task automatic test_dep_pair();
        int base;
        int acc;
        start_test("dep_pair");
        base = iss_edge.size();
        fetch(2'b11, r_type(5'd7, 5'd1, 5'd2), r_type(5'd8, 5'd7, 5'd3), acc);
        wait_drain();
        check_val("split edge", 32'(iss_edge[base] + 1), 32'(iss_edge[base + 1]));
        // x0 as destination is no write and keeps the pair together
        base = iss_edge.size();
        fetch(2'b11, i_type(5'd0, 5'd1, 12'd5), r_type(5'd9, 5'd0, 5'd2), acc);
        wait_drain();
        check_val("x0 pair edge", 32'(iss_edge[base]), 32'(iss_edge[base + 1]));
        end_test();
    endtask

    task automatic test_hold_backpressure();
        int          base;
        int          acc;
        int          accepted;
        int          n;
        logic [31:0] i0;
        logic [31:0] i1;
        logic [31:0] rd;
        start_test("hold_backpressure");
        base     = iss_edge.size();
        accepted = 0;
        n        = 0;
        wb_write(issue_pkg::CSR_CTRL, 32'd1 << issue_pkg::CTRL_HOLD_BIT);
        while (o_fetch_ready) begin
            if (n == TIMEOUT) abort_run("filling the queue");
            i0 = gen_inst();
            i1 = gen_inst();
            fetch(2'b11, i0, i1, acc);
            accepted += 2;
            n++;
        end
        wait_cycles(2);  // last pair still in decode
        wb_read(issue_pkg::CSR_STATUS, rd);
        check_val("status", 32'(accepted), rd);
        check_val("accepted at least 12", 32'd1, 32'(accepted >= 12));
        check_val("issued under hold", 32'(base), 32'(iss_edge.size()));
        wb_write(issue_pkg::CSR_CTRL, 32'd0);
        wait_drain();
        check_val("issued after release", 32'(base + accepted), 32'(iss_edge.size()));
        end_test();
    endtask

    task automatic test_flush();
        int          base;
        int          acc;
        logic [31:0] rd;
        start_test("flush");
        wb_write(issue_pkg::CSR_CTRL, 32'd1 << issue_pkg::CTRL_HOLD_BIT);
        repeat (3) begin
            fetch(2'b11, gen_inst(), gen_inst(), acc);
        end
        wait_cycles(2);
        wb_read(issue_pkg::CSR_STATUS, rd);
        check_val("status before flush", 32'd6, rd);
        base = iss_edge.size();
        wb_write(issue_pkg::CSR_CTRL, (32'd1 << issue_pkg::CTRL_FLUSH_BIT) |
                                      (32'd1 << issue_pkg::CTRL_HOLD_BIT));
        model_pc.delete();
        model_inst.delete();
        wait_cycles(1);
        wb_read(issue_pkg::CSR_STATUS, rd);
        check_val("status after flush", 32'd0, rd);
        wb_read(issue_pkg::CSR_CTRL, rd);
        check_val("ctrl readback", 32'd1, rd);  // flush bit reads 0
        wb_write(issue_pkg::CSR_CTRL, 32'd0);
        wait_cycles(5);
        check_val("issued after flush", 32'(base), 32'(iss_edge.size()));
        fetch(2'b11, r_type(5'd10, 5'd1, 5'd2), r_type(5'd11, 5'd3, 5'd4), acc);
        wait_drain();
        check_val("issued after refetch", 32'(base + 2), 32'(iss_edge.size()));
        end_test();
    endtask

    task automatic test_counter();
        int          acc;
        logic [31:0] rd;
        start_test("counter");
        wb_read(issue_pkg::CSR_ISSUED, rd);
        check_val("issued count", 32'(model_issued), rd);
        wb_read(2'd3, rd);
        check_val("unused address", 32'd0, rd);
        wb_write(issue_pkg::CSR_ISSUED, 32'hffff_ffff);
        model_issued = 0;
        wb_read(issue_pkg::CSR_ISSUED, rd);
        check_val("issued cleared", 32'd0, rd);
        fetch(2'b11, r_type(5'd12, 5'd1, 5'd2), r_type(5'd13, 5'd3, 5'd4), acc);
        wait_drain();
        wb_read(issue_pkg::CSR_ISSUED, rd);
        check_val("issued after pair", 32'(model_issued), rd);
        end_test();
    endtask

    task automatic test_random_stream();
        int          sent;
        int          acc;
        int          start_cnt;
        logic [31:0] r;
        logic [31:0] i0;
        logic [31:0] i1;
        start_test("random_stream");
        for (int i = 1; i < 32; i++) begin
            write_reg(5'(i), lcg_next());
        end
        start_cnt = iss_edge.size();
        sent      = 0;
        while (sent < 40) begin
            r  = lcg_next();
            i0 = gen_inst();
            i1 = gen_inst();
            if ((r[31:30] == 2'd0) || (sent == 39)) begin  // now and then a lone slot
                fetch(2'b01, i0, i1, acc);
                sent += 1;
            end else begin
                fetch(2'b11, i0, i1, acc);
                sent += 2;
            end
        end
        wait_drain();
        check_val("issued", 32'd40, 32'(iss_edge.size() - start_cnt));
        end_test();
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        rstn          = 1'b0;
        i_fetch_valid = 2'b00;
        i_fetch_pc    = '0;
        i_inst0       = '0;
        i_inst1       = '0;
        i_wr_en       = 1'b0;
        i_wr_addr     = '0;
        i_wr_data     = '0;
        i_wb_cyc      = 1'b0;
        i_wb_stb      = 1'b0;
        i_wb_we       = 1'b0;
        i_wb_adr      = 2'd0;
        i_wb_dat      = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
        end
        repeat (3) @(posedge clk);
        #5;
        rstn = 1'b1;
        test_reset_state();
        test_indep_pair();
        test_dep_pair();
        test_hold_backpressure();
        test_flush();
        test_counter();
        test_random_stream();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/issue_pkg.sv
hw/inst_decode.sv
issue_queue/issue_queue.sv
issue_queue/issue_select.sv
hw/reg_file.sv
hw/issue_csr.sv
hw/issue_top.sv
sim/tb_issue.sv
